// ==== ecc_mem_settings.svh ====
`ifndef ECC_MEM_SETTINGS_SVH
`define ECC_MEM_SETTINGS_SVH

// data word width.
`define ECC_DATA_W 28

// check bits per word.
`define ECC_PAR_W 7

// 64 entries in the array.
`define ECC_ADDR_W 6

// saturating error counter width.
`define ECC_CNT_W 16

`endif

// ==== ecc_mem_pkg.sv ====
`default_nettype none

`include "ecc_mem_settings.svh"

package ecc_mem_pkg;

    // stored word with parity in the upper bits.
    typedef struct packed {
        logic [`ECC_PAR_W-1:0]  parity;
        logic [`ECC_DATA_W-1:0] data;
    } code_fields_t;

    // flat view for storage and fault injection.
    typedef union packed {
        logic [`ECC_PAR_W+`ECC_DATA_W-1:0] flat;
        code_fields_t                      f;
    } codeword_t;

    // check bits of a data word for encoder and syndrome.
    function automatic logic [`ECC_PAR_W-1:0] ecc_parity(
        input logic [`ECC_DATA_W-1:0] d
    );
        logic [`ECC_PAR_W-1:0] p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11]
             ^ d[13] ^ d[15] ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12]
             ^ d[13] ^ d[16] ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14]
             ^ d[15] ^ d[16] ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25];
        p[3] = (^d[10:4]) ^ (^d[25:18]);
        p[4] = ^d[25:11];
        p[5] = ^d[27:26];
        // overall bit keeps every data syndrome at odd weight.
        p[6] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12]
             ^ d[14] ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27];
        return p;
    endfunction

endpackage

`default_nettype wire

// ==== ecc_mem_if.sv ====
`default_nettype none

`include "ecc_mem_settings.svh"

// controller to codeword array.
interface mem_port_if import ecc_mem_pkg::*; ();
    logic                   write_en;
    logic [`ECC_ADDR_W-1:0] waddr;
    codeword_t              wcode;
    logic                   read_en;
    logic [`ECC_ADDR_W-1:0] raddr;
    codeword_t              rcode;

    modport ctrl (output write_en, waddr, wcode, read_en, raddr, input rcode);
    modport ram (input write_en, waddr, wcode, read_en, raddr, output rcode);
endinterface

// one pulse per completed read.
interface err_event_if;
    logic                   valid;
    logic                   sbit_err;
    logic                   dbit_err;
    logic [`ECC_ADDR_W-1:0] addr;

    modport src (output valid, sbit_err, dbit_err, addr);
    modport log (input valid, sbit_err, dbit_err, addr);
endinterface

`default_nettype wire

// ==== ecc_28_codec.sv ====
`default_nettype none

`include "ecc_mem_settings.svh"

module ecc_28_codec import ecc_mem_pkg::*; (
    input  logic [`ECC_DATA_W-1:0] data_in,
    input  logic [`ECC_PAR_W-1:0]  parity_in,
    input  logic                   bypass,
    output logic [`ECC_DATA_W-1:0] data_out,
    output logic                   sbit_err,
    output logic                   dbit_err
);

    logic [`ECC_PAR_W-1:0]  syndrome;
    logic [`ECC_DATA_W-1:0] mask;
    logic                   par_hit;
    logic                   single_err;
    logic                   double_err;

    assign syndrome = parity_in ^ ecc_parity(data_in);

    // syndrome to flipped data bit.
    always_comb begin
        mask = '0;
        par_hit = 1'b0;
        case (syndrome)
            7'b0000000: mask = '0;
            7'b1000011: mask = 28'h0000001;
            7'b1000101: mask = 28'h0000002;
            7'b1000110: mask = 28'h0000004;
            7'b0000111: mask = 28'h0000008;
            7'b1001001: mask = 28'h0000010;
            7'b1001010: mask = 28'h0000020;
            7'b0001011: mask = 28'h0000040;
            7'b1001100: mask = 28'h0000080;
            7'b0001101: mask = 28'h0000100;
            7'b0001110: mask = 28'h0000200;
            7'b1001111: mask = 28'h0000400;
            7'b1010001: mask = 28'h0000800;
            7'b1010010: mask = 28'h0001000;
            7'b0010011: mask = 28'h0002000;
            7'b1010100: mask = 28'h0004000;
            7'b0010101: mask = 28'h0008000;
            7'b0010110: mask = 28'h0010000;
            7'b1010111: mask = 28'h0020000;
            7'b1011000: mask = 28'h0040000;
            7'b0011001: mask = 28'h0080000;
            7'b0011010: mask = 28'h0100000;
            7'b1011011: mask = 28'h0200000;
            7'b0011100: mask = 28'h0400000;
            7'b1011101: mask = 28'h0800000;
            7'b1011110: mask = 28'h1000000;
            7'b0011111: mask = 28'h2000000;
            7'b1100001: mask = 28'h4000000;
            7'b1100010: mask = 28'h8000000;
            // a flipped check bit leaves the data alone.
            7'b1000000, 7'b0100000, 7'b0010000, 7'b0001000,
            7'b0000100, 7'b0000010, 7'b0000001: par_hit = 1'b1;
            default: mask = '0;
        endcase
    end

    // anything else nonzero is treated as two flipped bits.
    assign single_err = (|mask) | par_hit;
    assign double_err = (syndrome != '0) & ~single_err;

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = ~bypass & single_err;
    assign dbit_err = ~bypass & double_err;

endmodule

`default_nettype wire

// ==== ecc_code_ram.sv ====
`default_nettype none

`include "ecc_mem_settings.svh"

module ecc_code_ram import ecc_mem_pkg::*; (
    input logic      clk,
    mem_port_if.ram  mem
);

    codeword_t store [0:(1 << `ECC_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (mem.write_en) begin
            store[mem.waddr] <= mem.wcode;
        end
    end

    // read-first, so a same-address write shows next time.
    always_ff @(posedge clk) begin
        if (mem.read_en) begin
            mem.rcode <= store[mem.raddr];
        end
    end

endmodule

`default_nettype wire

// ==== ecc_mem_ctrl.sv ====
`default_nettype none

`include "ecc_mem_settings.svh"

module ecc_mem_ctrl import ecc_mem_pkg::*; (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              write_en,
    input  logic [`ECC_ADDR_W-1:0]            write_addr,
    input  logic [`ECC_DATA_W-1:0]            write_data,
    input  logic [`ECC_PAR_W+`ECC_DATA_W-1:0] inject_mask,
    input  logic                              read_en,
    input  logic [`ECC_ADDR_W-1:0]            read_addr,
    input  logic                              bypass,
    output logic                              rd_valid,
    output logic [`ECC_DATA_W-1:0]            rd_data,
    output logic                              rd_sbit_err,
    output logic                              rd_dbit_err,
    mem_port_if.ctrl                          mem,
    err_event_if.src                          evt
);

    codeword_t              enc_word;
    logic                   rd_pend;
    logic [`ECC_ADDR_W-1:0] rd_addr_q;
    logic                   bypass_q;
    logic [`ECC_DATA_W-1:0] dec_data;
    logic                   dec_sbit;
    logic                   dec_dbit;
    logic [`ECC_ADDR_W-1:0] evt_addr_q;

    always_comb begin
        enc_word.f.data = write_data;
        enc_word.f.parity = ecc_parity(write_data);
    end

    // faults go in on the flat word including check bits.
    assign mem.wcode = enc_word.flat ^ inject_mask;
    assign mem.write_en = write_en;
    assign mem.waddr = write_addr;
    assign mem.read_en = read_en;
    assign mem.raddr = read_addr;

    // first stage lines up with the array read.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= read_en;
        end
        rd_addr_q <= read_addr;
        bypass_q <= bypass;
    end

    ecc_28_codec u_codec (
        .data_in   (mem.rcode.f.data),
        .parity_in (mem.rcode.f.parity),
        .bypass    (bypass_q),
        .data_out  (dec_data),
        .sbit_err  (dec_sbit),
        .dbit_err  (dec_dbit)
    );

    // second stage registers the results.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
            rd_sbit_err <= 1'b0;
            rd_dbit_err <= 1'b0;
        end else begin
            rd_valid <= rd_pend;
            rd_sbit_err <= rd_pend & dec_sbit;
            rd_dbit_err <= rd_pend & dec_dbit;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend) begin
            rd_data <= dec_data;
            evt_addr_q <= rd_addr_q;
        end
    end

    assign evt.valid = rd_valid;
    assign evt.sbit_err = rd_sbit_err;
    assign evt.dbit_err = rd_dbit_err;
    assign evt.addr = evt_addr_q;

endmodule

`default_nettype wire

// ==== ecc_err_log.sv ====
`default_nettype none

`include "ecc_mem_settings.svh"

module ecc_err_log (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clear_counts,
    err_event_if.log               evt,
    output logic [`ECC_CNT_W-1:0]  sbit_count,
    output logic [`ECC_CNT_W-1:0]  dbit_count,
    output logic [`ECC_ADDR_W-1:0] last_err_addr
);

    logic sbit_full;
    logic dbit_full;

    // counters stick at all ones.
    assign sbit_full = &sbit_count;
    assign dbit_full = &dbit_count;

    // clear beats a same-cycle event.
    always_ff @(posedge clk) begin
        if (reset || clear_counts) begin
            sbit_count <= '0;
            dbit_count <= '0;
            last_err_addr <= '0;
        end else if (evt.valid) begin
            if (evt.sbit_err && !sbit_full) begin
                sbit_count <= sbit_count + {{(`ECC_CNT_W-1){1'b0}}, 1'b1};
            end
            if (evt.dbit_err && !dbit_full) begin
                dbit_count <= dbit_count + {{(`ECC_CNT_W-1){1'b0}}, 1'b1};
            end
            if (evt.sbit_err || evt.dbit_err) begin
                last_err_addr <= evt.addr;
            end
        end
    end

endmodule

`default_nettype wire

// ==== ecc_mem_top.sv ====
`default_nettype none

`include "ecc_mem_settings.svh"

module ecc_mem_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              write_en,
    input  logic [`ECC_ADDR_W-1:0]            write_addr,
    input  logic [`ECC_DATA_W-1:0]            write_data,
    input  logic [`ECC_PAR_W+`ECC_DATA_W-1:0] inject_mask,
    input  logic                              read_en,
    input  logic [`ECC_ADDR_W-1:0]            read_addr,
    input  logic                              bypass,
    input  logic                              clear_counts,
    output logic                              rd_valid,
    output logic [`ECC_DATA_W-1:0]            rd_data,
    output logic                              rd_sbit_err,
    output logic                              rd_dbit_err,
    output logic [`ECC_CNT_W-1:0]             sbit_count,
    output logic [`ECC_CNT_W-1:0]             dbit_count,
    output logic [`ECC_ADDR_W-1:0]            last_err_addr
);

    mem_port_if  u_mem_if ();
    err_event_if u_evt_if ();

    ecc_mem_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .write_en    (write_en),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .inject_mask (inject_mask),
        .read_en     (read_en),
        .read_addr   (read_addr),
        .bypass      (bypass),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .rd_sbit_err (rd_sbit_err),
        .rd_dbit_err (rd_dbit_err),
        .mem         (u_mem_if.ctrl),
        .evt         (u_evt_if.src)
    );

    ecc_code_ram u_ram (
        .clk (clk),
        .mem (u_mem_if.ram)
    );

    ecc_err_log u_log (
        .clk           (clk),
        .reset         (reset),
        .clear_counts  (clear_counts),
        .evt           (u_evt_if.log),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

endmodule

`default_nettype wire

// ==== ecc_mem_assertions.sv ====
`default_nettype none

module ecc_mem_assertions (
    input logic clk,
    input logic reset,
    input logic read_en,
    input logic rd_valid,
    input logic rd_sbit_err,
    input logic rd_dbit_err
);

    // one error class per result.
    flags_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(rd_sbit_err && rd_dbit_err))
        else $error("rd_sbit_err and rd_dbit_err high together");

    // result two edges after the read is sampled.
    read_gives_valid: assert property (@(posedge clk) disable iff (reset)
        read_en |-> ##2 rd_valid)
        else $error("rd_valid missing two edges after read_en");

    valid_needs_read: assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> $past(read_en, 2))
        else $error("rd_valid without a read two edges earlier");

    flags_need_valid: assert property (@(posedge clk) disable iff (reset)
        !rd_valid |-> (!rd_sbit_err && !rd_dbit_err))
        else $error("error flag high while rd_valid is low");

endmodule

bind ecc_mem_top ecc_mem_assertions u_assertions (
    .clk         (clk),
    .reset       (reset),
    .read_en     (read_en),
    .rd_valid    (rd_valid),
    .rd_sbit_err (rd_sbit_err),
    .rd_dbit_err (rd_dbit_err)
);

`default_nettype wire

// ==== tb_ecc_mem.sv ====
`default_nettype none

`include "ecc_mem_settings.svh"

module tb_ecc_mem;

    localparam int MASK_W = `ECC_PAR_W + `ECC_DATA_W;
    localparam int READ_TIMEOUT = 10;

    logic                   clk;
    logic                   reset;
    logic                   write_en;
    logic [`ECC_ADDR_W-1:0] write_addr;
    logic [`ECC_DATA_W-1:0] write_data;
    logic [MASK_W-1:0]      inject_mask;
    logic                   read_en;
    logic [`ECC_ADDR_W-1:0] read_addr;
    logic                   bypass;
    logic                   clear_counts;
    logic                   rd_valid;
    logic [`ECC_DATA_W-1:0] rd_data;
    logic                   rd_sbit_err;
    logic                   rd_dbit_err;
    logic [`ECC_CNT_W-1:0]  sbit_count;
    logic [`ECC_CNT_W-1:0]  dbit_count;
    logic [`ECC_ADDR_W-1:0] last_err_addr;

    // expected results of reads in flight.
    logic [`ECC_DATA_W-1:0] exp_data_q [$];
    logic                   exp_sbit_q [$];
    logic                   exp_dbit_q [$];
    logic [`ECC_ADDR_W-1:0] exp_addr_q [$];

    int                     sbit_tally;
    int                     dbit_tally;
    logic [`ECC_ADDR_W-1:0] last_addr_tally;
    bit                     log_due;
    int                     error_count;
    int                     test_errors;
    int                     tests_passed;
    int                     tests_failed;
    int                     cur_test;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ecc_mem_top u_ecc_mem_top (
        .clk           (clk),
        .reset         (reset),
        .write_en      (write_en),
        .write_addr    (write_addr),
        .write_data    (write_data),
        .inject_mask   (inject_mask),
        .read_en       (read_en),
        .read_addr     (read_addr),
        .bypass        (bypass),
        .clear_counts  (clear_counts),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .rd_sbit_err   (rd_sbit_err),
        .rd_dbit_err   (rd_dbit_err),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            error_count++;
            test_errors++;
        end
    endtask

    // the log lags rd_valid by one edge.
    task automatic sample_outputs();
        if (log_due) begin
            check_value(64'(sbit_count), 64'(sbit_tally), "sbit_count");
            check_value(64'(dbit_count), 64'(dbit_tally), "dbit_count");
            check_value(64'(last_err_addr), 64'(last_addr_tally), "last_err_addr");
            log_due = 1'b0;
        end
        if (rd_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("read result at time %0t with no read pending", $time);
                error_count++;
                test_errors++;
            end else begin
                check_value(64'(rd_data), 64'(exp_data_q[0]), "rd_data");
                check_value(64'(rd_sbit_err), 64'(exp_sbit_q[0]), "rd_sbit_err");
                check_value(64'(rd_dbit_err), 64'(exp_dbit_q[0]), "rd_dbit_err");
                if (exp_sbit_q[0]) sbit_tally++;
                if (exp_dbit_q[0]) dbit_tally++;
                if (exp_sbit_q[0] || exp_dbit_q[0]) last_addr_tally = exp_addr_q[0];
                void'(exp_data_q.pop_front());
                void'(exp_sbit_q.pop_front());
                void'(exp_dbit_q.pop_front());
                void'(exp_addr_q.pop_front());
                log_due = 1'b1;
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
        sample_outputs();
    endtask

    task automatic drain_reads();
        int waited;
        waited = 0;
        while ((exp_data_q.size() > 0 || log_due) && waited < READ_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (exp_data_q.size() > 0) begin
            $display("timeout: %0d read result(s) never arrived within %0d cycles",
                     exp_data_q.size(), READ_TIMEOUT);
            error_count++;
            test_errors++;
            exp_data_q.delete();
            exp_sbit_q.delete();
            exp_dbit_q.delete();
            exp_addr_q.delete();
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) tests_passed++;
        else tests_failed++;
        $display("test %0d: %s, %0d error(s)", cur_test,
                 (test_errors == 0) ? "pass" : "fail", test_errors);
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        // 10 is a newline.
        while (c != 10 && c != -1) c = $fgetc(fd);
    endtask

    initial begin
        int                     fd;
        int                     r;
        int                     test_num;
        bit                     more;
        logic [7:0]             op;
        logic [`ECC_ADDR_W-1:0] addr;
        logic [`ECC_DATA_W-1:0] data;
        logic [`ECC_DATA_W-1:0] exp_data;
        logic [MASK_W-1:0]      mask;
        logic                   byp;
        logic                   exp_s;
        logic                   exp_d;
        reset = 1'b1;
        write_en = 1'b0;
        write_addr = '0;
        write_data = '0;
        inject_mask = '0;
        read_en = 1'b0;
        read_addr = '0;
        bypass = 1'b0;
        clear_counts = 1'b0;
        sbit_tally = 0;
        dbit_tally = 0;
        last_addr_tally = '0;
        log_due = 1'b0;
        error_count = 0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        cur_test = -1;
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
        check_value(64'(rd_valid), 64'd0, "rd_valid after reset");
        check_value(64'(sbit_count), 64'd0, "sbit_count after reset");
        check_value(64'(dbit_count), 64'd0, "dbit_count after reset");
        fd = $fopen("ecc_mem_input.txt", "r");
        if (fd == 0) begin
            $display("could not open ecc_mem_input.txt");
            error_count++;
        end else begin
            more = 1'b1;
            while (more) begin
                r = $fscanf(fd, " %c", op);
                if (r != 1) begin
                    more = 1'b0;
                end else if (op == "#") begin
                    skip_line(fd);
                end else begin
                    r = $fscanf(fd, "%h %h %h %h %d %h %h %h", addr, data, mask, byp,
                                test_num, exp_data, exp_s, exp_d);
                    if (r != 8) begin
                        $display("malformed line in ecc_mem_input.txt after opcode %c", op);
                        error_count++;
                        more = 1'b0;
                    end else begin
                        if (test_num != cur_test) begin
                            drain_reads();
                            if (cur_test >= 0) finish_test();
                            cur_test = test_num;
                            test_errors = 0;
                        end
                        case (op)
                            "W": begin
                                drain_reads();
                                write_en = 1'b1;
                                write_addr = addr;
                                write_data = data;
                                inject_mask = mask;
                                next_cycle();
                                write_en = 1'b0;
                                inject_mask = '0;
                            end
                            "R": begin
                                read_en = 1'b1;
                                read_addr = addr;
                                bypass = byp;
                                exp_data_q.push_back(exp_data);
                                exp_sbit_q.push_back(exp_s);
                                exp_dbit_q.push_back(exp_d);
                                exp_addr_q.push_back(addr);
                                next_cycle();
                                read_en = 1'b0;
                                bypass = 1'b0;
                            end
                            "C": begin
                                drain_reads();
                                clear_counts = 1'b1;
                                next_cycle();
                                clear_counts = 1'b0;
                                sbit_tally = 0;
                                dbit_tally = 0;
                                last_addr_tally = '0;
                                check_value(64'(sbit_count), 64'd0, "sbit_count after clear");
                                check_value(64'(dbit_count), 64'd0, "dbit_count after clear");
                                check_value(64'(last_err_addr), 64'd0, "last_err_addr cleared");
                            end
                            default: begin
                                $display("unknown opcode %c in ecc_mem_input.txt", op);
                                error_count++;
                                test_errors++;
                            end
                        endcase
                    end
                end
            end
            $fclose(fd);
        end
        drain_reads();
        if (cur_test >= 0) finish_test();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ecc_mem_input.txt ====
# op addr data mask bypass test | exp_data exp_sbit exp_dbit (hex except test)
# op is W write, R read, C clear counts; unused columns are zero
W 01 a5c3e71 000000000 0 1 0000000 0 0
R 01 0000000 000000000 0 1 a5c3e71 0 0
W 02 1234567 000000001 0 2 0000000 0 0
W 03 89abcde 000000800 0 2 0000000 0 0
W 04 fedcba9 008000000 0 2 0000000 0 0
W 05 0f0f0f0 000010000 0 2 0000000 0 0
R 02 0000000 000000000 0 2 1234567 1 0
R 03 0000000 000000000 0 2 89abcde 1 0
R 04 0000000 000000000 0 2 fedcba9 1 0
R 05 0000000 000000000 0 2 0f0f0f0 1 0
W 06 5555555 010000000 0 3 0000000 0 0
W 07 2aaaaaa 400000000 0 3 0000000 0 0
R 06 0000000 000000000 0 3 5555555 1 0
R 07 0000000 000000000 0 3 2aaaaaa 1 0
W 08 3c3c3c3 000000005 0 4 0000000 0 0
W 09 0000000 200000100 0 4 0000000 0 0
R 08 0000000 000000000 0 4 3c3c3c6 0 1
R 09 0000000 000000000 0 4 0000100 0 1
R 02 0000000 000000000 1 5 1234566 0 0
R 08 0000000 000000000 1 5 3c3c3c6 0 0
W 0a 7654321 000000040 0 6 0000000 0 0
R 0a 0000000 000000000 0 6 7654321 1 0
C 00 0000000 000000000 0 6 0000000 0 0

// ==== ecc_mem.f ====
+incdir+.
ecc_mem_pkg.sv
ecc_mem_if.sv
ecc_28_codec.sv
ecc_code_ram.sv
ecc_mem_ctrl.sv
ecc_err_log.sv
ecc_mem_top.sv
ecc_mem_assertions.sv
tb_ecc_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ecc_mem
FLIST     ?= ecc_mem.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SHELL := /bin/bash
SRCS  := $(filter-out +%,$(shell cat $(FLIST)))
HDRS  := ecc_mem_settings.svh
BIN   := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	set -o pipefail; ./$(BIN) 2>&1 | tee $(LOG)
	! grep -q "SIMULATION FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
